/* filelist.f */
hdl/mem_stage_pkg.sv
hdl/mem_addr_decode.sv
hdl/dcache_ctrl.sv
hdl/load_result.sv
hdl/memory.sv
verif/host_mem_model.sv
verif/tb_memory.sv

/* hdl/dcache_ctrl.sv */
// direct-mapped write-back data cache with host miss handling for one access at a time
module dcache_ctrl (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                 [31:0] addr,
	input  logic                                 [31:0] data_in,
	input  logic                                        wr,
	input  mem_stage_pkg::access_kind_t                 access_kind,
	input  logic                                        access_valid,
	input  logic        [mem_stage_pkg::LINE_BITS-1:0] DataIn_host,
	input  logic                                        tx_done_host,
	input  logic                                        rd_valid_host,
	output logic                                 [31:0] hit_word,
	output logic                                        cache_ack,
	output logic        [mem_stage_pkg::LINE_BITS-1:0] DataOut_host,
	output logic                                 [31:0] AddrOut_host,
	output mem_stage_pkg::host_op_t                     op_host
);

	// fsm encoding
	localparam logic [1:0] ST_COMPARE   = 2'd0;
	localparam logic [1:0] ST_WRITEBACK = 2'd1;
	localparam logic [1:0] ST_FILL      = 2'd2;
	localparam logic [1:0] ST_ACK       = 2'd3;

	// request address in its cache split
	mem_stage_pkg::mem_addr_u req;

	// line address sent to the host
	mem_stage_pkg::mem_addr_u host_addr;

	logic [1:0] state;
	logic [1:0] state_nxt;

	// tag, data and per-line status
	logic [mem_stage_pkg::TAG_BITS-1:0] tag_q [mem_stage_pkg::NUM_LINES];
	logic [mem_stage_pkg::WORDS_PER_LINE-1:0][mem_stage_pkg::WORD_BITS-1:0]
		data_q [mem_stage_pkg::NUM_LINES];
	logic [mem_stage_pkg::NUM_LINES-1:0] valid_q;
	logic [mem_stage_pkg::NUM_LINES-1:0] dirty_q;

	// lookup results for the current request
	logic [mem_stage_pkg::INDEX_BITS-1:0] idx;
	logic [mem_stage_pkg::WORD_SEL_BITS-1:0] word_sel;
	logic is_cache;
	logic hit;
	logic victim_dirty;
	logic store_hit;
	logic wb_done;
	logic fill_done;

	// incoming line with the store word merged in
	logic [mem_stage_pkg::WORDS_PER_LINE-1:0][mem_stage_pkg::WORD_BITS-1:0] fill_line;

	assign req = addr;
	assign idx = req.cache.index;
	assign word_sel = req.cache.word;

	assign is_cache = (access_kind == mem_stage_pkg::ACC_CACHE);
	assign hit = valid_q[idx] && (tag_q[idx] == req.cache.tag);

	// victim must go back before the new line lands
	assign victim_dirty = valid_q[idx] && dirty_q[idx];

	assign store_hit = (state == ST_COMPARE) && access_valid && is_cache && hit && wr;
	assign wb_done = (state == ST_WRITEBACK) && tx_done_host;
	assign fill_done = (state == ST_FILL) && rd_valid_host;

	// store miss writes its word straight into the fetched line
	always_comb begin
		fill_line = DataIn_host;
		if (wr) begin
			fill_line[word_sel] = data_in;
		end
	end

	// next state and ack
	always_comb begin
		state_nxt = state;
		cache_ack = 1'b0;
		case (state)
			ST_COMPARE: begin
				if (access_valid) begin
					if (!is_cache || hit) begin
						// hit or uncached access answers now
						cache_ack = 1'b1;
						state_nxt = ST_ACK;
					end else if (victim_dirty) begin
						state_nxt = ST_WRITEBACK;
					end else begin
						state_nxt = ST_FILL;
					end
				end
			end
			ST_WRITEBACK: begin
				// back through compare for the idle cycle on op_host
				// compare then sees a clean miss
				if (tx_done_host) begin
					state_nxt = ST_COMPARE;
				end
			end
			ST_FILL: begin
				if (rd_valid_host) begin
					cache_ack = 1'b1;
					state_nxt = ST_ACK;
				end
			end
			default: begin
				// request still held in the done cycle and ignored
				state_nxt = ST_COMPARE;
			end
		endcase
	end

	// word handed to the result stage
	always_comb begin
		if (state == ST_FILL) begin
			hit_word = fill_line[word_sel];
		end else if (is_cache) begin
			hit_word = data_q[idx][word_sel];
		end else begin
			// uncached region reads as zero
			hit_word = '0;
		end
	end

	// op_host follows the state and holds until the answer
	always_comb begin
		case (state)
			ST_WRITEBACK: op_host = mem_stage_pkg::HOST_WRITE;
			ST_FILL:      op_host = mem_stage_pkg::HOST_READ;
			default:      op_host = mem_stage_pkg::HOST_IDLE;
		endcase
	end

	// line aligned host address
	// victim tag during write-back and request tag otherwise
	always_comb begin
		host_addr = req;
		if (state == ST_WRITEBACK) begin
			host_addr.cache.tag = tag_q[idx];
		end
		host_addr.cache.word = '0;
		host_addr.cache.byte_off = '0;
	end

	assign AddrOut_host = host_addr;

	// victim line at the request index
	assign DataOut_host = data_q[idx];

	// fsm and line status
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_COMPARE;
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			state <= state_nxt;
			if (store_hit) begin
				dirty_q[idx] <= 1'b1;
			end
			if (wb_done) begin
				dirty_q[idx] <= 1'b0;
			end
			if (fill_done) begin
				valid_q[idx] <= 1'b1;
				// store miss leaves the new line dirty
				dirty_q[idx] <= wr;
			end
		end
	end

	// tag and data arrays
	always_ff @(posedge clk) begin
		if (store_hit) begin
			data_q[idx][word_sel] <= data_in;
		end
		if (fill_done) begin
			data_q[idx] <= fill_line;
			tag_q[idx] <= req.cache.tag;
		end
	end

	// request to the host is held until it answers
	a_op_host_held: assert property (@(posedge clk) disable iff (reset)
		(op_host != mem_stage_pkg::HOST_IDLE && !tx_done_host && !rd_valid_host)
		|=> ($stable(op_host) && $stable(AddrOut_host)))
		else $error("host request changed before the host answered");

	// write completion only answers a write
	a_tx_done_on_write: assert property (@(posedge clk) disable iff (reset)
		tx_done_host |-> (op_host == mem_stage_pkg::HOST_WRITE))
		else $error("tx_done_host outside HOST_WRITE");

endmodule

/* hdl/load_result.sv */
// result stage of the memory stage that registers the load word and makes done and stall
module load_result (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] hit_word,
	input  logic        cache_ack,
	input  logic        wr,
	input  logic        access_valid,
	output logic [31:0] mem_data,
	output logic        done,
	output logic        stall
);

	// acknowledged load is the only thing that updates mem_data
	logic load_ack;

	assign load_ack = cache_ack && !wr;

	// one cycle done pulse
	// controller sits in its ack state during the done cycle
	// so cache_ack cannot repeat back to back
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= cache_ack;
		end
	end

	// load word held until the next load
	// stores leave it alone
	always_ff @(posedge clk) begin
		if (load_ack) begin
			mem_data <= hit_word;
		end
	end

	// pipeline waits while a request is up and not yet answered
	assign stall = access_valid && !done;

	// done is a pulse of one cycle
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done high for two cycles");

	// an ack only answers a live request from the pipeline
	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		cache_ack |-> access_valid)
		else $error("cache_ack without a request");

	// request is held through the done cycle
	a_req_held: assert property (@(posedge clk) disable iff (reset)
		cache_ack |=> access_valid)
		else $error("request dropped before done");

endmodule

/* hdl/mem_addr_decode.sv */
// address decode for the memory stage that sorts each access into cached, FPU start or MMIO
module mem_addr_decode #(
	parameter logic [31:0] FPU_START_ADDR = 32'h1000_0000
) (
	input  logic                        [31:0] addr,
	input  logic                               wr,
	input  logic                               en,
	output mem_stage_pkg::access_kind_t        access_kind,
	output logic                               access_valid,
	output logic                               startFPU
);

	// address seen through the mmio split
	mem_stage_pkg::mem_addr_u req;

	// upper half matches the register space
	logic in_mmio;

	// store aimed at the FPU kick register
	logic fpu_store;

	assign req = addr;

	// only the region half is compared here
	assign in_mmio = (req.mmio.region == mem_stage_pkg::MMIO_REGION);

	// full word compare so the start address may sit anywhere
	assign fpu_store = wr && (addr == FPU_START_ADDR);

	// fpu start wins over the generic region match
	always_comb begin
		if (fpu_store) begin
			access_kind = mem_stage_pkg::ACC_FPU_START;
		end else if (in_mmio) begin
			access_kind = mem_stage_pkg::ACC_MMIO;
		end else begin
			access_kind = mem_stage_pkg::ACC_CACHE;
		end
	end

	// request presented this cycle
	// the held copy in the done cycle is dropped by the controller in its ack state
	assign access_valid = en;

	// kick the FPU for as long as the store is presented
	// FPU sees the kick in the same cycle
	assign startFPU = en && (access_kind == mem_stage_pkg::ACC_FPU_START);

	// the FPU kick only ever comes from a live store
	always_comb begin
		assert #0 (!startFPU || (en && wr))
			else $error("startFPU raised without a live store");
	end

endmodule

/* hdl/mem_stage_pkg.sv */
// shared address union, host op codes and cache geometry for the memory stage, used by scoped name
package mem_stage_pkg;

	// host port and cache line width
	localparam int LINE_BITS = 512;
	localparam int WORD_BITS = 32;
	localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

	// address split, byte then word then index then tag
	localparam int BYTE_SEL_BITS = 2;
	localparam int WORD_SEL_BITS = 4;
	localparam int INDEX_BITS = 4;
	localparam int NUM_LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = WORD_BITS - INDEX_BITS - WORD_SEL_BITS - BYTE_SEL_BITS;

	// upper address half of the uncached register space
	localparam logic [15:0] MMIO_REGION = 16'h1000;

	// op_host encoding toward the memory controller
	typedef enum logic [1:0] {
		HOST_IDLE  = 2'd0,
		HOST_READ  = 2'd1,
		HOST_WRITE = 2'd2
	} host_op_t;

	// decode result for one access
	typedef enum logic [1:0] {
		ACC_CACHE     = 2'd0,
		ACC_FPU_START = 2'd1,
		ACC_MMIO      = 2'd2
	} access_kind_t;

	// one address word seen as a cache address or as an mmio address
	typedef union packed {
		struct packed {
			logic [TAG_BITS-1:0]      tag;
			logic [INDEX_BITS-1:0]    index;
			logic [WORD_SEL_BITS-1:0] word;
			logic [BYTE_SEL_BITS-1:0] byte_off;
		} cache;
		struct packed {
			logic [15:0] region;
			logic [15:0] reg_off;
		} mmio;
	} mem_addr_u;

endpackage

/* hdl/memory.sv */
// memory stage top level, wires address decode, data cache controller and load result together
module memory #(
	parameter logic [31:0] FPU_START_ADDR = 32'h1000_0000
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                 [31:0] ExMe_out_alu_out,
	input  logic                                 [31:0] ExMe_out_reg_2_data,
	input  logic                                        ExMe_out_mem_wrt,
	input  logic                                        ExMe_out_mem_en,
	input  logic        [mem_stage_pkg::LINE_BITS-1:0] DataIn_host,
	input  logic                                        tx_done_host,
	input  logic                                        rd_valid_host,
	output logic                                 [31:0] mem_data,
	output logic                                        done,
	output logic                                        stall,
	output logic        [mem_stage_pkg::LINE_BITS-1:0] DataOut_host,
	output logic                                 [31:0] AddrOut_host,
	output mem_stage_pkg::host_op_t                     op_host,
	output logic                                        startFPU
);

	// decode to controller and result
	mem_stage_pkg::access_kind_t access_kind;
	logic access_valid;

	// controller to result
	logic [31:0] hit_word;
	logic cache_ack;

	// classify, and kick the FPU
	mem_addr_decode #(
		.FPU_START_ADDR(FPU_START_ADDR)
	) i_decode (
		.addr        (ExMe_out_alu_out),
		.wr          (ExMe_out_mem_wrt),
		.en          (ExMe_out_mem_en),
		.access_kind (access_kind),
		.access_valid(access_valid),
		.startFPU    (startFPU)
	);

	// cache lookup and host traffic
	dcache_ctrl i_dcache (
		.clk          (clk),
		.reset        (reset),
		.addr         (ExMe_out_alu_out),
		.data_in      (ExMe_out_reg_2_data),
		.wr           (ExMe_out_mem_wrt),
		.access_kind  (access_kind),
		.access_valid (access_valid),
		.DataIn_host  (DataIn_host),
		.tx_done_host (tx_done_host),
		.rd_valid_host(rd_valid_host),
		.hit_word     (hit_word),
		.cache_ack    (cache_ack),
		.DataOut_host (DataOut_host),
		.AddrOut_host (AddrOut_host),
		.op_host      (op_host)
	);

	// registered load word and done
	load_result i_result (
		.clk         (clk),
		.reset       (reset),
		.hit_word    (hit_word),
		.cache_ack   (cache_ack),
		.wr          (ExMe_out_mem_wrt),
		.access_valid(access_valid),
		.mem_data    (mem_data),
		.done        (done),
		.stall       (stall)
	);

endmodule

/* verif/host_mem_model.sv */
// behavioural host memory controller for the testbench, answers op_host after a random delay
module host_mem_model (
	input  logic                                  clk,
	input  logic                                  reset,
	input  mem_stage_pkg::host_op_t               op_host,
	input  logic                           [31:0] AddrOut_host,
	input  logic [mem_stage_pkg::LINE_BITS-1:0] DataOut_host,
	output logic [mem_stage_pkg::LINE_BITS-1:0] DataIn_host,
	output logic                                  tx_done_host,
	output logic                                  rd_valid_host
);

	// lines written back so far, everything else reads as the fill pattern
	logic [31:0] line_addr [64];
	logic [mem_stage_pkg::LINE_BITS-1:0] line_data [64];
	int line_count;
	logic [31:0] seed;
	logic busy;
	int remain;

	// lcg step for the response delay
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// fill pattern uses the full word address, then any written line on top
	function automatic logic [mem_stage_pkg::LINE_BITS-1:0] read_line(input logic [31:0] addr);
		logic [mem_stage_pkg::LINE_BITS-1:0] line;
		for (int w = 0; w < 16; w++) begin
			line[w*32 +: 32] = (addr + 32'(w * 4)) ^ 32'hA5A5_0000;
		end
		for (int i = 0; i < line_count; i++) begin
			if (line_addr[i] == addr) begin
				line = line_data[i];
			end
		end
		return line;
	endfunction

	// answers are driven 2 units after the edge, like the pipeline side
	initial begin
		DataIn_host = '0;
		tx_done_host = 1'b0;
		rd_valid_host = 1'b0;
		seed = 32'd90785;
		busy = 1'b0;
		remain = 0;
		line_count = 0;
		forever begin
			@(posedge clk);
			#2;
			tx_done_host = 1'b0;
			rd_valid_host = 1'b0;
			if (reset) begin
				busy = 1'b0;
			end else begin
				// new request, pick a delay of 1 to 8 cycles
				if (!busy && op_host != mem_stage_pkg::HOST_IDLE) begin
					seed = lcg_next(seed);
					remain = 1 + int'(seed[18:16]);
					busy = 1'b1;
				end
				if (busy) begin
					remain--;
					if (remain == 0) begin
						busy = 1'b0;
						if (op_host == mem_stage_pkg::HOST_WRITE) begin
							line_addr[line_count] = AddrOut_host;
							line_data[line_count] = DataOut_host;
							line_count++;
							tx_done_host = 1'b1;
						end else begin
							DataIn_host = read_line(AddrOut_host);
							rd_valid_host = 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

/* verif/memory_trace.txt */
# op address store_data expected_load, all hex
# op L load, S store, F store to the FPU start address
L 00000040 00000000 a5a50040
L 00000044 00000000 a5a50044
S 00000048 cafe0001 00000000
L 00000048 00000000 cafe0001
L 00000448 00000000 a5a50448
L 00000048 00000000 cafe0001
S 00000100 12345678 00000000
L 0000013c 00000000 a5a5013c
F 10000000 00000001 00000000
L 10000008 00000000 00000000
S 10000010 deadbeef 00000000
L 00000500 00000000 a5a50500
L 00000100 00000000 12345678
S 00000104 0badf00d 00000000
L 00000904 00000000 a5a50904
L 00000104 00000000 0badf00d
L 00000100 00000000 12345678
L 00000fc0 00000000 a5a50fc0
S 00000ffc 11112222 00000000
L 00000ffc 00000000 11112222
L 00002000 00000000 a5a52000
L 00002004 00000000 a5a52004

/* verif/tb_memory.sv */
// trace-driven testbench for the memory stage, run from the project root with the host model attached
module tb_memory;

	localparam logic [31:0] FPU_ADDR = 32'h1000_0000;
	localparam int WAIT_LIMIT = 100;

	logic clk;
	logic reset;
	logic [31:0] ExMe_out_alu_out;
	logic [31:0] ExMe_out_reg_2_data;
	logic ExMe_out_mem_wrt;
	logic ExMe_out_mem_en;
	logic [mem_stage_pkg::LINE_BITS-1:0] DataIn_host;
	logic tx_done_host;
	logic rd_valid_host;
	logic [31:0] mem_data;
	logic done;
	logic stall;
	logic [mem_stage_pkg::LINE_BITS-1:0] DataOut_host;
	logic [31:0] AddrOut_host;
	mem_stage_pkg::host_op_t op_host;
	logic startFPU;

	int checks;
	int value_errors;
	int other_errors;
	logic timed_out;

	// host requests seen during the current access
	mem_stage_pkg::host_op_t seen_op [$];
	logic [31:0] seen_addr [$];
	logic [mem_stage_pkg::LINE_BITS-1:0] seen_line [$];

	// expected cache state, tag is addr[31:10], index addr[9:6]
	logic [21:0] shadow_tag [16];
	logic [15:0] shadow_valid;
	logic [15:0] shadow_dirty;

	// every cached store so far, last one wins
	logic [31:0] store_addr [64];
	logic [31:0] store_data [64];
	int store_count;
	logic [31:0] last_load;
	logic have_load;

	memory #(
		.FPU_START_ADDR(FPU_ADDR)
	) i_dut (
		.clk                (clk),
		.reset              (reset),
		.ExMe_out_alu_out   (ExMe_out_alu_out),
		.ExMe_out_reg_2_data(ExMe_out_reg_2_data),
		.ExMe_out_mem_wrt   (ExMe_out_mem_wrt),
		.ExMe_out_mem_en    (ExMe_out_mem_en),
		.DataIn_host        (DataIn_host),
		.tx_done_host       (tx_done_host),
		.rd_valid_host      (rd_valid_host),
		.mem_data           (mem_data),
		.done               (done),
		.stall              (stall),
		.DataOut_host       (DataOut_host),
		.AddrOut_host       (AddrOut_host),
		.op_host            (op_host),
		.startFPU           (startFPU)
	);

	host_mem_model i_host (
		.clk          (clk),
		.reset        (reset),
		.op_host      (op_host),
		.AddrOut_host (AddrOut_host),
		.DataOut_host (DataOut_host),
		.DataIn_host  (DataIn_host),
		.tx_done_host (tx_done_host),
		.rd_valid_host(rd_valid_host)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input mem_stage_pkg::host_op_t got,
			input mem_stage_pkg::host_op_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("FAIL time=%0t %s got=%s expected=%s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, exp);
		end
	endtask

	// word the host would hold for an address, stores applied
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [31:0] word;
		word = addr ^ 32'hA5A5_0000;
		for (int i = 0; i < store_count; i++) begin
			if (store_addr[i] == addr) begin
				word = store_data[i];
			end
		end
		return word;
	endfunction

	// host op monitor, sampled 1 unit after the edge
	// an op may only change once the host has answered
	initial begin
		mem_stage_pkg::host_op_t prev_op;
		prev_op = mem_stage_pkg::HOST_IDLE;
		forever begin
			@(posedge clk);
			#1;
			if (reset) begin
				prev_op = mem_stage_pkg::HOST_IDLE;
			end else begin
				if (prev_op != mem_stage_pkg::HOST_IDLE && !tx_done_host && !rd_valid_host) begin
					check_op("op_host", op_host, prev_op);
				end
				if (op_host != mem_stage_pkg::HOST_IDLE && prev_op == mem_stage_pkg::HOST_IDLE) begin
					seen_op.push_back(op_host);
					seen_addr.push_back(AddrOut_host);
					seen_line.push_back(DataOut_host);
				end
				prev_op = op_host;
			end
		end
	end

	// one access, entered and left 2 units after an edge
	task automatic run_access(input logic [7:0] op_ch, input logic [31:0] addr,
			input logic [31:0] data, input logic [31:0] exp);
		logic is_store;
		logic is_fpu;
		logic is_mmio;
		logic hit;
		logic victim_dirty;
		logic got_done;
		logic [3:0] idx;
		logic [31:0] victim_base;
		logic [mem_stage_pkg::LINE_BITS-1:0] victim;
		int cycles;
		int k;
		is_store = (op_ch == "S") || (op_ch == "F");
		is_fpu = is_store && (addr == FPU_ADDR);
		is_mmio = (addr[31:16] == 16'h1000);
		idx = addr[9:6];
		victim_base = {shadow_tag[idx], idx, 6'd0};
		hit = shadow_valid[idx] && (shadow_tag[idx] == addr[31:10]);
		victim_dirty = shadow_valid[idx] && shadow_dirty[idx];
		seen_op.delete();
		seen_addr.delete();
		seen_line.delete();
		ExMe_out_alu_out = addr;
		ExMe_out_reg_2_data = data;
		ExMe_out_mem_wrt = is_store;
		ExMe_out_mem_en = 1'b1;
		cycles = 0;
		got_done = 1'b0;
		// stall must hold until done, startFPU only on the FPU store
		while (!got_done && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
			check_bit("startFPU", startFPU, is_fpu);
			if (done) begin
				got_done = 1'b1;
			end else begin
				check_bit("stall", stall, 1'b1);
			end
		end
		if (!got_done) begin
			other_errors++;
			timed_out = 1'b1;
			$display("ERROR at %0t: no done within %0d cycles for access to %h",
				$time, WAIT_LIMIT, addr);
		end else begin
			check_bit("stall", stall, 1'b0);
			if (!is_store) begin
				check_word("mem_data", mem_data, exp);
				last_load = exp;
				have_load = 1'b1;
			end else if (have_load) begin
				// stores leave the load word alone
				check_word("mem_data", mem_data, last_load);
			end
			if (is_mmio || hit) begin
				check_word("done latency", cycles, 1);
				check_word("host op count", seen_op.size(), 0);
			end else if (seen_op.size() != (victim_dirty ? 2 : 1)) begin
				other_errors++;
				$display("ERROR at %0t: miss on %h made %0d host requests, expected %0d",
					$time, addr, seen_op.size(), victim_dirty ? 2 : 1);
			end else begin
				k = 0;
				if (victim_dirty) begin
					// dirty victim goes out whole before the fill
					victim = seen_line[0];
					check_op("op_host", seen_op[0], mem_stage_pkg::HOST_WRITE);
					check_word("AddrOut_host", seen_addr[0], victim_base);
					for (int w = 0; w < 16; w++) begin
						check_word($sformatf("DataOut_host word %0d", w), victim[w*32 +: 32],
							expected_word(victim_base + 32'(w * 4)));
					end
					k = 1;
				end
				check_op("op_host", seen_op[k], mem_stage_pkg::HOST_READ);
				check_word("AddrOut_host", seen_addr[k], {addr[31:6], 6'd0});
			end
			if (!is_mmio) begin
				shadow_valid[idx] = 1'b1;
				shadow_tag[idx] = addr[31:10];
				shadow_dirty[idx] = is_store || (hit && shadow_dirty[idx]);
			end
			if (is_store && !is_mmio && store_count < 64) begin
				store_addr[store_count] = addr;
				store_data[store_count] = data;
				store_count++;
			end
			// done is a single pulse
			@(posedge clk);
			#1;
			check_bit("done", done, 1'b0);
			#1;
		end
		ExMe_out_mem_en = 1'b0;
		ExMe_out_mem_wrt = 1'b0;
	endtask

	initial begin
		int fd;
		int fields;
		int accesses;
		string line;
		logic [7:0] op_ch;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
		ExMe_out_alu_out = '0;
		ExMe_out_reg_2_data = '0;
		ExMe_out_mem_wrt = 1'b0;
		ExMe_out_mem_en = 1'b0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		shadow_valid = '0;
		shadow_dirty = '0;
		store_count = 0;
		have_load = 1'b0;
		accesses = 0;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		// quiet outputs before the first access
		repeat (4) begin
			@(posedge clk);
			#1;
			check_op("op_host", op_host, mem_stage_pkg::HOST_IDLE);
			check_bit("done", done, 1'b0);
			check_bit("stall", stall, 1'b0);
			check_bit("startFPU", startFPU, 1'b0);
			#1;
		end
		fd = $fopen("verif/memory_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("ERROR: the access trace could not be opened");
		end else begin
			while (!timed_out && $fgets(line, fd) > 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%c %h %h %h", op_ch, addr, data, exp);
					if (fields != 4 || !(op_ch == "L" || op_ch == "S" || op_ch == "F")) begin
						other_errors++;
						$display("ERROR: malformed trace line: %s", line);
					end else begin
						run_access(op_ch, addr, data, exp);
						accesses++;
					end
				end
			end
			$fclose(fd);
		end
		if (accesses == 0) begin
			other_errors++;
			$display("ERROR: no access was run from the trace");
		end
		$display("accesses %0d, checks %0d, value errors %0d, other errors %0d",
			accesses, checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
